//--- flist.f
+incdir+.
rv_pkg.sv
rv_stage_ctrl.sv
rv_pc_counter.sv
rv_decoder.sv
rv_regfile.sv
rv_alu.sv
rv_writeback.sv
rv_wb_master.sv
rv_core.sv
tb_rv_core.sv

//--- rv_alu.sv
`timescale 1ns/10ps
`include "rv_defs.svh"

module rv_alu (
    input  logic             i_clk,
    input  logic             i_rst,
    input  logic             i_opnd_latch,
    input  logic             i_exec_en,
    input  rv_pkg::op1_sel_e i_op1_sel,
    input  rv_pkg::op2_sel_e i_op2_sel,
    input  rv_pkg::alu_op_e  i_alu_op,
    input  rv_pkg::word_t    i_pc,
    input  rv_pkg::word_t    i_rs1_data,
    input  rv_pkg::word_t    i_rs2_data,
    input  rv_pkg::word_t    i_imm,
    input  rv_pkg::funct3_t  i_funct3,
    input  logic             i_is_branch,
    input  logic             i_is_jump,
    output rv_pkg::word_t    o_result,
    output rv_pkg::word_t    o_load_addr,
    output logic             o_redirect
);

    rv_pkg::word_t op1;
    rv_pkg::word_t op2;
    rv_pkg::word_t cmp_a;     // rs1 value, also the load base
    rv_pkg::word_t cmp_b;
    rv_pkg::word_t alu_out;
    logic [4:0]    shamt;
    logic          take;

    assign shamt = op2[4:0]; // shift immediates only matter in their low 5 bits

    always_ff @(posedge i_clk) begin
        if (i_opnd_latch) begin
            op1   <= (i_op1_sel == rv_pkg::OP1_PC) ? i_pc : i_rs1_data;
            case (i_op2_sel)
                rv_pkg::OP2_RS2:   op2 <= i_rs2_data;
                default:           op2 <= i_imm;
            endcase
            cmp_a <= i_rs1_data;
            cmp_b <= i_rs2_data;
        end
    end

    always_comb begin
        case (i_alu_op)
            rv_pkg::ALU_SUB:  alu_out = op1 - op2;
            rv_pkg::ALU_SLT:  alu_out = {{(`RV_XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
            rv_pkg::ALU_SLTU: alu_out = {{(`RV_XLEN-1){1'b0}}, op1 < op2};
            rv_pkg::ALU_XOR:  alu_out = op1 ^ op2;
            rv_pkg::ALU_OR:   alu_out = op1 | op2;
            rv_pkg::ALU_AND:  alu_out = op1 & op2;
            rv_pkg::ALU_SLL:  alu_out = op1 << shamt;
            rv_pkg::ALU_SRL:  alu_out = op1 >> shamt;
            rv_pkg::ALU_SRA:  alu_out = rv_pkg::word_t'($signed(op1) >>> shamt);
            default:          alu_out = op1 + op2;
        endcase
    end

    always_comb begin
        case (i_funct3)
            `RV_F3_BEQ:  take = (cmp_a == cmp_b);
            `RV_F3_BNE:  take = (cmp_a != cmp_b);
            `RV_F3_BLT:  take = ($signed(cmp_a) < $signed(cmp_b));
            `RV_F3_BGE:  take = ($signed(cmp_a) >= $signed(cmp_b));
            `RV_F3_BLTU: take = (cmp_a < cmp_b);
            `RV_F3_BGEU: take = (cmp_a >= cmp_b);
            default:     take = 1'b0;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_exec_en) begin
            // jump targets are halfword aligned, as JALR requires
            o_result <= i_is_jump ? {alu_out[`RV_XLEN-1:1], 1'b0} : alu_out;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_redirect <= 1'b0;
        end else if (i_exec_en) begin
            o_redirect <= i_is_jump || (i_is_branch && take);
        end
    end

    assign o_load_addr = cmp_a + i_imm;

endmodule

//--- rv_core.sv
`timescale 1ns/10ps

module rv_core (
    input  logic          i_clk,
    input  logic          i_rst,
    input  logic          i_ack,
    input  logic          i_stall,
    input  rv_pkg::word_t i_data,
    output logic          o_cyc,
    output logic          o_stb,
    output rv_pkg::word_t o_addr
);

    logic              fetch_req;
    logic              dec_latch;
    logic              opnd_latch;
    logic              exec_en;
    logic              load_req;
    logic              wb_en;
    logic              bus_done;
    rv_pkg::word_t     rdata;
    rv_pkg::word_t     pc;
    rv_pkg::word_t     next_pc;
    rv_pkg::reg_addr_t rs1;
    rv_pkg::reg_addr_t rs2;
    rv_pkg::reg_addr_t rd;
    rv_pkg::word_t     imm;
    rv_pkg::funct3_t   funct3;
    rv_pkg::alu_op_e   alu_op;
    rv_pkg::op1_sel_e  op1_sel;
    rv_pkg::op2_sel_e  op2_sel;
    rv_pkg::wb_sel_e   wb_sel;
    logic              is_load;
    logic              is_branch;
    logic              is_jump;
    rv_pkg::word_t     rs1_data;
    rv_pkg::word_t     rs2_data;
    rv_pkg::word_t     alu_result;
    rv_pkg::word_t     load_addr;
    logic              redirect;
    logic              rf_we;
    rv_pkg::word_t     rf_wdata;

    rv_stage_ctrl u_stage_ctrl (
        .i_clk(i_clk), .i_rst(i_rst), .i_bus_done(bus_done), .i_is_load(is_load),
        .o_fetch_req(fetch_req), .o_dec_latch(dec_latch), .o_opnd_latch(opnd_latch),
        .o_exec_en(exec_en), .o_load_req(load_req), .o_wb_en(wb_en)
    );

    rv_pc_counter u_pc_counter (
        .i_clk(i_clk), .i_rst(i_rst), .i_fetch(fetch_req), .i_wb_en(wb_en),
        .i_redirect(redirect), .i_target(alu_result), .o_pc(pc), .o_next_pc(next_pc)
    );

    rv_decoder u_decoder (
        .i_clk(i_clk), .i_rst(i_rst), .i_latch(dec_latch), .i_instr(rdata),
        .o_rs1(rs1), .o_rs2(rs2), .o_rd(rd), .o_imm(imm), .o_funct3(funct3),
        .o_alu_op(alu_op), .o_op1_sel(op1_sel), .o_op2_sel(op2_sel), .o_wb_sel(wb_sel),
        .o_is_load(is_load), .o_is_branch(is_branch), .o_is_jump(is_jump)
    );

    rv_regfile u_regfile (
        .i_clk(i_clk), .i_rst(i_rst), .i_rs1(rs1), .i_rs2(rs2), .i_rd(rd),
        .i_we(rf_we), .i_wdata(rf_wdata), .o_rs1_data(rs1_data), .o_rs2_data(rs2_data)
    );

    rv_alu u_alu (
        .i_clk(i_clk), .i_rst(i_rst), .i_opnd_latch(opnd_latch), .i_exec_en(exec_en),
        .i_op1_sel(op1_sel), .i_op2_sel(op2_sel), .i_alu_op(alu_op), .i_pc(pc),
        .i_rs1_data(rs1_data), .i_rs2_data(rs2_data), .i_imm(imm), .i_funct3(funct3),
        .i_is_branch(is_branch), .i_is_jump(is_jump), .o_result(alu_result),
        .o_load_addr(load_addr), .o_redirect(redirect)
    );

    rv_writeback u_writeback (
        .i_wb_en(wb_en), .i_wb_sel(wb_sel), .i_funct3(funct3), .i_byte_off(load_addr[1:0]),
        .i_load_data(rdata), .i_imm(imm), .i_alu_result(alu_result), .i_link(next_pc),
        .o_we(rf_we), .o_wdata(rf_wdata)
    );

    rv_wb_master u_wb_master (
        .i_clk(i_clk), .i_rst(i_rst), .i_fetch_req(fetch_req), .i_load_req(load_req),
        .i_fetch_addr(next_pc), .i_load_addr(load_addr), .i_ack(i_ack), .i_stall(i_stall),
        .i_data(i_data), .o_cyc(o_cyc), .o_stb(o_stb), .o_addr(o_addr), .o_rdata(rdata),
        .o_done(bus_done)
    );

endmodule

//--- rv_decoder.sv
`timescale 1ns/10ps
`include "rv_defs.svh"

module rv_decoder (
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              i_latch,
    input  rv_pkg::word_t     i_instr,
    output rv_pkg::reg_addr_t o_rs1,
    output rv_pkg::reg_addr_t o_rs2,
    output rv_pkg::reg_addr_t o_rd,
    output rv_pkg::word_t     o_imm,
    output rv_pkg::funct3_t   o_funct3,
    output rv_pkg::alu_op_e   o_alu_op,
    output rv_pkg::op1_sel_e  o_op1_sel,
    output rv_pkg::op2_sel_e  o_op2_sel,
    output rv_pkg::wb_sel_e   o_wb_sel,
    output logic              o_is_load,
    output logic              o_is_branch,
    output logic              o_is_jump
);

    logic [6:0]      opcode;
    logic [6:0]      funct7;
    rv_pkg::funct3_t funct3;
    rv_pkg::alu_op_e f3_op;
    logic            is_shift;

    assign opcode   = i_instr[6:0];
    assign funct3   = i_instr[14:12];
    assign funct7   = i_instr[31:25];
    assign is_shift = (funct3 == `RV_F3_SLL) || (funct3 == `RV_F3_SR);

    always_comb begin
        case (funct3)
            `RV_F3_ADD:  f3_op = rv_pkg::ALU_ADD;
            `RV_F3_SLL:  f3_op = rv_pkg::ALU_SLL;
            `RV_F3_SLT:  f3_op = rv_pkg::ALU_SLT;
            `RV_F3_SLTU: f3_op = rv_pkg::ALU_SLTU;
            `RV_F3_XOR:  f3_op = rv_pkg::ALU_XOR;
            `RV_F3_SR:   f3_op = (funct7 == `RV_F7_ALT) ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            `RV_F3_OR:   f3_op = rv_pkg::ALU_OR;
            default:     f3_op = rv_pkg::ALU_AND;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_latch) begin
            o_rs1    <= i_instr[19:15];
            o_rs2    <= i_instr[24:20];
            o_rd     <= i_instr[11:7];
            o_funct3 <= funct3;
            case (opcode)
                `RV_OP_LUI, `RV_OP_AUIPC:
                    o_imm <= {i_instr[31:12], 12'b0};
                `RV_OP_JAL:
                    o_imm <= {{12{i_instr[31]}}, i_instr[19:12], i_instr[20],
                              i_instr[30:21], 1'b0};
                `RV_OP_BRANCH:
                    o_imm <= {{20{i_instr[31]}}, i_instr[7], i_instr[30:25],
                              i_instr[11:8], 1'b0};
                default:
                    o_imm <= {{20{i_instr[31]}}, i_instr[31:20]}; // I-type
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_alu_op    <= rv_pkg::ALU_ADD;
            o_op1_sel   <= rv_pkg::OP1_RS1;
            o_op2_sel   <= rv_pkg::OP2_IMM;
            o_wb_sel    <= rv_pkg::WB_NONE;
            o_is_load   <= 1'b0;
            o_is_branch <= 1'b0;
            o_is_jump   <= 1'b0;
        end else if (i_latch) begin
            o_alu_op    <= rv_pkg::ALU_ADD; // targets and addresses are sums
            o_op1_sel   <= rv_pkg::OP1_RS1;
            o_op2_sel   <= rv_pkg::OP2_IMM;
            o_wb_sel    <= rv_pkg::WB_NONE; // unknown opcodes retire as no-op
            o_is_load   <= (opcode == `RV_OP_LOAD);
            o_is_branch <= (opcode == `RV_OP_BRANCH);
            o_is_jump   <= (opcode == `RV_OP_JAL) || (opcode == `RV_OP_JALR);
            case (opcode)
                `RV_OP_LUI:    o_wb_sel <= rv_pkg::WB_IMM;
                `RV_OP_AUIPC: begin
                    o_op1_sel <= rv_pkg::OP1_PC;
                    o_wb_sel  <= rv_pkg::WB_ALU;
                end
                `RV_OP_JAL: begin
                    o_op1_sel <= rv_pkg::OP1_PC;
                    o_wb_sel  <= rv_pkg::WB_LINK;
                end
                `RV_OP_JALR:   o_wb_sel <= rv_pkg::WB_LINK;
                `RV_OP_BRANCH: o_op1_sel <= rv_pkg::OP1_PC;
                `RV_OP_IMM: begin
                    o_alu_op  <= f3_op;
                    o_op2_sel <= is_shift ? rv_pkg::OP2_SHAMT : rv_pkg::OP2_IMM;
                    o_wb_sel  <= rv_pkg::WB_ALU;
                end
                `RV_OP_REG: begin
                    if (funct3 == `RV_F3_ADD && funct7 == `RV_F7_ALT) begin
                        o_alu_op <= rv_pkg::ALU_SUB;
                    end else begin
                        o_alu_op <= f3_op;
                    end
                    o_op2_sel <= rv_pkg::OP2_RS2;
                    o_wb_sel  <= rv_pkg::WB_ALU;
                end
                `RV_OP_LOAD:   o_wb_sel <= rv_pkg::WB_LOAD;
                default:       ;
            endcase
        end
    end

endmodule

//--- rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

`define RV_XLEN      32
`define RV_NR_REGS   32
`define RV_PC_RESET  32'h2040_0000

`define RV_OP_LUI    7'b0110111
`define RV_OP_AUIPC  7'b0010111
`define RV_OP_JAL    7'b1101111
`define RV_OP_JALR   7'b1100111
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_IMM    7'b0010011
`define RV_OP_REG    7'b0110011
`define RV_OP_LOAD   7'b0000011

`define RV_F3_BEQ    3'b000
`define RV_F3_BNE    3'b001
`define RV_F3_BLT    3'b100
`define RV_F3_BGE    3'b101
`define RV_F3_BLTU   3'b110
`define RV_F3_BGEU   3'b111

`define RV_F3_ADD    3'b000
`define RV_F3_SLL    3'b001
`define RV_F3_SLT    3'b010
`define RV_F3_SLTU   3'b011
`define RV_F3_XOR    3'b100
`define RV_F3_SR     3'b101
`define RV_F3_OR     3'b110
`define RV_F3_AND    3'b111

`define RV_F3_LB     3'b000
`define RV_F3_LH     3'b001
`define RV_F3_LW     3'b010
`define RV_F3_LBU    3'b100
`define RV_F3_LHU    3'b101

`define RV_F7_ALT    7'b0100000

`endif

//--- rv_pc_counter.sv
`timescale 1ns/10ps
`include "rv_defs.svh"

module rv_pc_counter (
    input  logic          i_clk,
    input  logic          i_rst,
    input  logic          i_fetch,
    input  logic          i_wb_en,
    input  logic          i_redirect,
    input  rv_pkg::word_t i_target,
    output rv_pkg::word_t o_pc,
    output rv_pkg::word_t o_next_pc
);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_pc      <= `RV_PC_RESET;
            o_next_pc <= `RV_PC_RESET;
        end else if (i_fetch) begin
            o_pc      <= o_next_pc;
            o_next_pc <= o_next_pc + 4; // also the link value until writeback
        end else if (i_wb_en && i_redirect) begin
            o_next_pc <= i_target;      // taken branch or jump
        end
    end

endmodule

//--- rv_pkg.sv
`include "rv_defs.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [4:0]          reg_addr_t;
    typedef logic [2:0]          funct3_t;

    typedef enum logic [2:0] {
        ST_FETCH,
        ST_FETCH_WAIT,
        ST_DECODE,
        ST_PREPARE,
        ST_EXECUTE,
        ST_LOAD,
        ST_LOAD_WAIT,
        ST_WRITEBACK
    } stage_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_op_e;

    typedef enum logic {OP1_RS1, OP1_PC} op1_sel_e;

    typedef enum logic [1:0] {OP2_RS2, OP2_IMM, OP2_SHAMT} op2_sel_e;

    typedef enum logic [2:0] {WB_NONE, WB_IMM, WB_ALU, WB_LINK, WB_LOAD} wb_sel_e;

endpackage

//--- rv_regfile.sv
`timescale 1ns/10ps
`include "rv_defs.svh"

module rv_regfile (
    input  logic              i_clk,
    input  logic              i_rst,
    input  rv_pkg::reg_addr_t i_rs1,
    input  rv_pkg::reg_addr_t i_rs2,
    input  rv_pkg::reg_addr_t i_rd,
    input  logic              i_we,
    input  rv_pkg::word_t     i_wdata,
    output rv_pkg::word_t     o_rs1_data,
    output rv_pkg::word_t     o_rs2_data
);

    rv_pkg::word_t regs [`RV_NR_REGS];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < `RV_NR_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && i_rd != '0) begin
            regs[i_rd] <= i_wdata;
        end
    end

    assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1]; // x0 is hardwired
    assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

//--- rv_stage_ctrl.sv
`timescale 1ns/10ps

module rv_stage_ctrl (
    input  logic i_clk,
    input  logic i_rst,
    input  logic i_bus_done,
    input  logic i_is_load,
    output logic o_fetch_req,
    output logic o_dec_latch,
    output logic o_opnd_latch,
    output logic o_exec_en,
    output logic o_load_req,
    output logic o_wb_en
);

    rv_pkg::stage_e state;
    rv_pkg::stage_e state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            rv_pkg::ST_FETCH:      state_nxt = rv_pkg::ST_FETCH_WAIT;
            rv_pkg::ST_FETCH_WAIT: if (i_bus_done) state_nxt = rv_pkg::ST_DECODE;
            rv_pkg::ST_DECODE:     state_nxt = rv_pkg::ST_PREPARE;
            rv_pkg::ST_PREPARE:    state_nxt = rv_pkg::ST_EXECUTE;
            rv_pkg::ST_EXECUTE:    state_nxt = i_is_load ? rv_pkg::ST_LOAD : rv_pkg::ST_WRITEBACK;
            rv_pkg::ST_LOAD:       state_nxt = rv_pkg::ST_LOAD_WAIT;
            rv_pkg::ST_LOAD_WAIT:  if (i_bus_done) state_nxt = rv_pkg::ST_WRITEBACK;
            default:               state_nxt = rv_pkg::ST_FETCH; // writeback retires
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state <= rv_pkg::ST_FETCH;
        end else begin
            state <= state_nxt;
        end
    end

    // one strobe per stage, each high for a single cycle
    assign o_fetch_req  = (state == rv_pkg::ST_FETCH);
    assign o_dec_latch  = (state == rv_pkg::ST_DECODE);
    assign o_opnd_latch = (state == rv_pkg::ST_PREPARE);
    assign o_exec_en    = (state == rv_pkg::ST_EXECUTE);
    assign o_load_req   = (state == rv_pkg::ST_LOAD);
    assign o_wb_en      = (state == rv_pkg::ST_WRITEBACK);

endmodule

//--- rv_wb_master.sv
`timescale 1ns/10ps

module rv_wb_master (
    input  logic          i_clk,
    input  logic          i_rst,
    input  logic          i_fetch_req,
    input  logic          i_load_req,
    input  rv_pkg::word_t i_fetch_addr,
    input  rv_pkg::word_t i_load_addr,
    input  logic          i_ack,
    input  logic          i_stall,
    input  rv_pkg::word_t i_data,
    output logic          o_cyc,
    output logic          o_stb,
    output rv_pkg::word_t o_addr,
    output rv_pkg::word_t o_rdata,
    output logic          o_done
);

    logic ack_ok;

    assign ack_ok = o_cyc && i_ack && !i_stall;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_cyc  <= 1'b0;
            o_stb  <= 1'b0;
            o_addr <= '0;
            o_done <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if (i_fetch_req || i_load_req) begin
                o_cyc  <= 1'b1;
                o_stb  <= 1'b1;
                o_addr <= i_load_req ? i_load_addr : i_fetch_addr;
            end else if (o_stb && !i_stall) begin
                o_stb <= 1'b0; // request accepted, wait for ack
            end
            if (ack_ok) begin
                o_cyc  <= 1'b0;
                o_addr <= '0;
                o_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (ack_ok) begin
            o_rdata <= i_data;
        end
    end

endmodule

//--- rv_writeback.sv
`timescale 1ns/10ps
`include "rv_defs.svh"

module rv_writeback (
    input  logic            i_wb_en,
    input  rv_pkg::wb_sel_e i_wb_sel,
    input  rv_pkg::funct3_t i_funct3,
    input  logic [1:0]      i_byte_off,
    input  rv_pkg::word_t   i_load_data,
    input  rv_pkg::word_t   i_imm,
    input  rv_pkg::word_t   i_alu_result,
    input  rv_pkg::word_t   i_link,
    output logic            o_we,
    output rv_pkg::word_t   o_wdata
);

    logic [7:0]    ld_byte;
    logic [15:0]   ld_half;
    rv_pkg::word_t ld_val;

    assign ld_byte = i_load_data[8*i_byte_off +: 8];
    assign ld_half = i_byte_off[1] ? i_load_data[31:16] : i_load_data[15:0];

    always_comb begin
        case (i_funct3)
            `RV_F3_LB:  ld_val = {{24{ld_byte[7]}}, ld_byte};
            `RV_F3_LH:  ld_val = {{16{ld_half[15]}}, ld_half};
            `RV_F3_LBU: ld_val = {24'b0, ld_byte};
            `RV_F3_LHU: ld_val = {16'b0, ld_half};
            default:    ld_val = i_load_data; // LW
        endcase
    end

    always_comb begin
        case (i_wb_sel)
            rv_pkg::WB_IMM:  o_wdata = i_imm;
            rv_pkg::WB_LINK: o_wdata = i_link;
            rv_pkg::WB_LOAD: o_wdata = ld_val;
            default:         o_wdata = i_alu_result;
        endcase
    end

    assign o_we = i_wb_en && (i_wb_sel != rv_pkg::WB_NONE);

endmodule

//--- tb_rv_core.sv
`timescale 1ns/10ps

module tb_rv_core;

    localparam int          MAX_ROWS = 80;
    localparam logic [31:0] BASE     = 32'h2040_0000;
    localparam logic [6:0]  OP_LUI   = 7'h37;
    localparam logic [6:0]  OP_AUIPC = 7'h17;
    localparam logic [6:0]  OP_JALR  = 7'h67;
    localparam logic [6:0]  OP_IMM   = 7'h13;
    localparam logic [6:0]  OP_LOAD  = 7'h03;

    logic          i_clk;
    logic          i_rst;
    logic          i_ack;
    logic          i_stall;
    rv_pkg::word_t i_data;
    logic          o_cyc;
    logic          o_stb;
    rv_pkg::word_t o_addr;

    rv_pkg::word_t tbl_instr [MAX_ROWS];  // fetched word
    logic          tbl_load  [MAX_ROWS];
    rv_pkg::word_t tbl_ldata [MAX_ROWS];  // word returned to the load
    rv_pkg::word_t tbl_exp   [MAX_ROWS];  // next bus address
    int            nr_rows;
    int            nr_checks;
    int            nr_errors;
    int            nr_accepts;
    int            cycles;
    int            cycle_limit;
    logic [31:0]   rnd_state;

    rv_core i_rv_core (
        .i_clk(i_clk), .i_rst(i_rst), .i_ack(i_ack), .i_stall(i_stall), .i_data(i_data),
        .o_cyc(o_cyc), .o_stb(o_stb), .o_addr(o_addr)
    );

    always #10 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        if (!i_rst && o_stb && !i_stall) begin
            nr_accepts = nr_accepts + 1; // request accepted on this edge
        end
    end

    always @(posedge i_clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout after %0d cycles, the core stopped answering", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic draw(input int span, output int val);
        rnd_state = xorshift(rnd_state);
        val = rnd_state % (span + 1);
    endtask

    function automatic rv_pkg::word_t r_type(input logic [2:0] f3, input logic [6:0] f7,
                                             input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic rv_pkg::word_t i_type(input logic [6:0] op, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [4:0] rs1,
                                             input int imm);
        logic [31:0] v;
        v = imm;
        return {v[11:0], rs1, f3, rd, op};
    endfunction

    function automatic rv_pkg::word_t u_type(input logic [6:0] op, input logic [4:0] rd,
                                             input logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic rv_pkg::word_t b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                             input logic [4:0] rs2, input int imm);
        logic [31:0] v;
        v = imm;
        return {v[12], v[10:5], rs2, rs1, f3, v[4:1], v[11], 7'h63};
    endfunction

    function automatic rv_pkg::word_t j_type(input logic [4:0] rd, input int imm);
        logic [31:0] v;
        v = imm;
        return {v[20], v[10:1], v[11], v[19:12], rd, 7'h6f};
    endfunction

    task automatic add_row(input rv_pkg::word_t instr, input rv_pkg::word_t exp);
        tbl_instr[nr_rows] = instr;
        tbl_load[nr_rows]  = 1'b0;
        tbl_ldata[nr_rows] = '0;
        tbl_exp[nr_rows]   = exp;
        nr_rows++;
    endtask

    task automatic add_load(input rv_pkg::word_t instr, input rv_pkg::word_t ldata,
                            input rv_pkg::word_t exp);
        tbl_instr[nr_rows] = instr;
        tbl_load[nr_rows]  = 1'b1;
        tbl_ldata[nr_rows] = ldata;
        tbl_exp[nr_rows]   = exp;
        nr_rows++;
    endtask

    task automatic build_program();
        add_row(u_type(OP_LUI, 1, 20'h12345), BASE + 'h04);          // x1 = 12345000
        add_load(i_type(OP_LOAD, 3'b010, 0, 1, 0), 0, 32'h1234_5000);
        add_row(u_type(OP_AUIPC, 2, 20'h00001), BASE + 'h0c);        // x2 = pc + 1000
        add_load(i_type(OP_LOAD, 3'b010, 0, 2, 0), 0, 32'h2040_1008);
        add_row(i_type(OP_IMM, 3'b000, 3, 0, -5), BASE + 'h14);
        add_row(i_type(OP_IMM, 3'b000, 4, 0, 12), BASE + 'h18);
        add_row(r_type(3'b000, 7'h00, 5, 3, 4), BASE + 'h1c);       // add
        add_load(i_type(OP_LOAD, 3'b010, 0, 5, 0), 0, 32'h0000_0007);
        add_row(r_type(3'b000, 7'h20, 6, 4, 3), BASE + 'h24);       // sub
        add_load(i_type(OP_LOAD, 3'b010, 0, 6, 0), 0, 32'h0000_0011);
        add_row(r_type(3'b100, 7'h00, 7, 1, 3), BASE + 'h2c);       // xor
        add_load(i_type(OP_LOAD, 3'b010, 0, 7, 0), 0, 32'hedcb_affb);
        add_row(r_type(3'b110, 7'h00, 8, 1, 4), BASE + 'h34);       // or
        add_load(i_type(OP_LOAD, 3'b010, 0, 8, 0), 0, 32'h1234_500c);
        add_row(r_type(3'b111, 7'h00, 9, 7, 8), BASE + 'h3c);       // and
        add_load(i_type(OP_LOAD, 3'b010, 0, 9, 0), 0, 32'h0000_0008);
        add_row(i_type(OP_IMM, 3'b100, 10, 4, 'h0f0), BASE + 'h44);  // xori
        add_row(i_type(OP_IMM, 3'b110, 11, 10, -256), BASE + 'h48);  // ori
        add_row(i_type(OP_IMM, 3'b111, 12, 11, 'h7f3), BASE + 'h4c); // andi
        add_load(i_type(OP_LOAD, 3'b010, 0, 12, 0), 0, 32'h0000_07f0);
        add_row(i_type(OP_IMM, 3'b001, 13, 1, 3), BASE + 'h54);      // slli
        add_load(i_type(OP_LOAD, 3'b010, 0, 13, 0), 0, 32'h91a2_8000);
        add_row(i_type(OP_IMM, 3'b101, 14, 13, 'h408), BASE + 'h5c); // srai of a negative
        add_load(i_type(OP_LOAD, 3'b010, 0, 14, 0), 0, 32'hff91_a280);
        add_row(i_type(OP_IMM, 3'b101, 15, 13, 8), BASE + 'h64);     // srli
        add_load(i_type(OP_LOAD, 3'b010, 0, 15, 0), 0, 32'h0091_a280);
        add_row(r_type(3'b001, 7'h00, 16, 3, 4), BASE + 'h6c);      // sll
        add_load(i_type(OP_LOAD, 3'b010, 0, 16, 0), 0, 32'hffff_b000);
        add_row(r_type(3'b101, 7'h20, 17, 13, 4), BASE + 'h74);     // sra
        add_load(i_type(OP_LOAD, 3'b010, 0, 17, 0), 0, 32'hfff9_1a28);
        add_row(r_type(3'b010, 7'h00, 18, 3, 4), BASE + 'h7c);      // slt
        add_load(i_type(OP_LOAD, 3'b010, 0, 18, 0), 0, 32'h0000_0001);
        add_row(r_type(3'b011, 7'h00, 5, 3, 4), BASE + 'h84);       // sltu overwrites 7
        add_load(i_type(OP_LOAD, 3'b010, 0, 5, 0), 0, 32'h0000_0000);
        add_row(i_type(OP_IMM, 3'b000, 0, 1, 'h55), BASE + 'h8c);    // write to x0
        add_load(i_type(OP_LOAD, 3'b010, 0, 0, 0), 0, 32'h0000_0000);
        add_row(b_type(3'b000, 4, 4, 8), BASE + 'h98);              // beq
        add_row(b_type(3'b000, 3, 4, 8), BASE + 'h9c);
        add_row(b_type(3'b001, 3, 4, 8), BASE + 'ha4);              // bne
        add_row(b_type(3'b001, 4, 4, 8), BASE + 'ha8);
        add_row(b_type(3'b100, 3, 4, 8), BASE + 'hb0);              // blt
        add_row(b_type(3'b100, 4, 3, 8), BASE + 'hb4);
        add_row(b_type(3'b101, 4, 3, 8), BASE + 'hbc);              // bge
        add_row(b_type(3'b101, 3, 4, 8), BASE + 'hc0);
        add_row(b_type(3'b110, 4, 3, 8), BASE + 'hc8);              // bltu
        add_row(b_type(3'b110, 3, 4, 8), BASE + 'hcc);
        add_row(b_type(3'b111, 3, 4, -'h40), BASE + 'h8c);          // bgeu, backwards
        add_row(b_type(3'b111, 4, 3, 8), BASE + 'h90);
        add_row(j_type(23, 'h100), BASE + 'h190);                   // jal
        add_load(i_type(OP_LOAD, 3'b010, 0, 23, 0), 0, 32'h2040_0094);
        add_row(i_type(OP_JALR, 3'b000, 24, 1, 'h21), 32'h1234_5020); // bit 0 cleared
        add_load(i_type(OP_LOAD, 3'b010, 0, 24, 0), 0, 32'h2040_0198);
        add_row(i_type(OP_JALR, 3'b000, 0, 23, -3), BASE + 'h90);
        add_row(j_type(0, -'h90), BASE);
        // each loaded value is the base of the next load
        add_load(i_type(OP_LOAD, 3'b000, 26, 1, 0), 32'h7e1f_83c2, 32'h1234_5000);
        add_load(i_type(OP_LOAD, 3'b000, 26, 26, 1), 32'h7e1f_83c2, 32'hffff_ffc3);
        add_load(i_type(OP_LOAD, 3'b000, 26, 26, 3), 32'h7e1f_83c2, 32'h0000_0081);
        add_load(i_type(OP_LOAD, 3'b000, 26, 26, -1), 32'h7e1f_83c2, 32'hffff_ff82);
        add_load(i_type(OP_LOAD, 3'b100, 26, 26, 1), 32'h7e1f_83c2, 32'h0000_0020);
        add_load(i_type(OP_LOAD, 3'b100, 26, 26, 3), 32'h7e1f_83c2, 32'h0000_00c5);
        add_load(i_type(OP_LOAD, 3'b100, 26, 26, 0), 32'h7e1f_83c2, 32'h0000_0083);
        add_load(i_type(OP_LOAD, 3'b100, 26, 26, 0), 32'h7e1f_83c2, 32'h0000_007e);
        add_load(i_type(OP_LOAD, 3'b001, 26, 26, 1), 32'h7e1f_83c2, 32'h0000_0020);
        add_load(i_type(OP_LOAD, 3'b001, 26, 26, 0), 32'h7e1f_83c2, 32'hffff_83c2);
        add_load(i_type(OP_LOAD, 3'b101, 26, 26, 1), 32'h7e1f_83c2, 32'h0000_7e20);
        add_load(i_type(OP_LOAD, 3'b101, 26, 26, 0), 32'h9a3b_1234, 32'h0000_83c2);
        add_load(i_type(OP_LOAD, 3'b010, 26, 26, 1), 32'h5566_a7b8, 32'h0000_9a3c);
        add_load(i_type(OP_LOAD, 3'b010, 0, 26, 0), 0, 32'h5566_a7b8);
    endtask

    task automatic check_addr(input string what, input rv_pkg::word_t got,
                              input rv_pkg::word_t exp);
        nr_checks++;
        if (got !== exp) begin
            nr_errors++;
            $display("** Error: %s o_addr = %h, expected %h", what, got, exp);
        end else begin
            $display("ok    %s o_addr = %h", what, got);
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        nr_checks++;
        if (got != exp) begin
            nr_errors++;
            $display("** Error: %s = %h, expected %h", what, got, exp);
        end else begin
            $display("ok    %s = %0d", what, got);
        end
    endtask

    // memory model, answers one request with random stall and ack delay
    task automatic serve(input rv_pkg::word_t rdata, output rv_pkg::word_t addr);
        int n_stall;
        int n_wait;
        while (!o_stb) @(negedge i_clk);
        addr = o_addr;
        draw(3, n_stall);
        draw(3, n_wait);
        repeat (n_stall) begin
            i_stall = 1'b1;
            @(negedge i_clk);
            if (!o_stb || !o_cyc) begin
                nr_errors++;
                $display("request at %h was withdrawn during a stall", addr);
            end
            if (o_addr !== addr) begin
                nr_errors++;
                $display("** Error: o_addr = %h under stall, expected %h", o_addr, addr);
            end
        end
        i_stall = 1'b0;
        @(negedge i_clk);
        repeat (n_wait) @(negedge i_clk);
        i_ack  = 1'b1;
        i_data = rdata;
        @(negedge i_clk);
        i_ack  = 1'b0;
        i_data = '0;
        if (o_cyc || o_addr !== '0) begin
            nr_errors++;
            $display("bus cycle for %h still open after the ack", addr);
        end
    endtask

    initial begin
        rv_pkg::word_t addr;
        rv_pkg::word_t pc_exp;
        int            nr_loads;
        i_clk       = 1'b0;
        i_rst       = 1'b1;
        i_ack       = 1'b0;
        i_stall     = 1'b0;
        i_data      = '0;
        cycles      = 0;
        nr_rows     = 0;
        nr_checks   = 0;
        nr_errors   = 0;
        nr_accepts  = 0;
        nr_loads    = 0;
        rnd_state   = 32'd51;
        build_program();
        cycle_limit = nr_rows * 60;
        repeat (8) @(posedge i_clk);
        @(negedge i_clk);
        i_rst  = 1'b0;
        pc_exp = BASE;
        for (int r = 0; r < nr_rows; r++) begin
            serve(tbl_instr[r], addr);
            check_addr($sformatf("row %0d fetch", r), addr, pc_exp);
            if (tbl_load[r]) begin
                nr_loads++;
                serve(tbl_ldata[r], addr);
                check_addr($sformatf("row %0d load", r), addr, tbl_exp[r]);
                pc_exp = pc_exp + 4;
            end else begin
                pc_exp = tbl_exp[r];
            end
        end
        serve(i_type(OP_IMM, 3'b000, 0, 0, 0), addr); // nop
        check_addr("last fetch", addr, pc_exp);
        check_count("accepted requests", nr_accepts, nr_rows + nr_loads + 1);
        $display("%0d checks, %0d errors, %0d cycles", nr_checks, nr_errors, cycles);
        if (nr_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
